// File: build.f
efpga_test_pkg.sv
oper_ram.sv
tcdm_dma_channel.sv
wb_csr_target.sv
efpga_test_top.sv
tb_tcdm_mem.sv
tb_efpga_test.sv

// File: Makefile
# Verilator build for the eFPGA test target testbench

VERILATOR ?= verilator
TOP       ?= tb_efpga_test
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_efpga_test.sv
`timescale 1ns/1ps

/*
  testbench for the eFPGA test target
  drives the Wishbone port, models TCDM behind both channels and
  checks pins, RAM windows, bursts and direct accesses
*/
module tb_efpga_test;

  import efpga_test_pkg::*;

  localparam logic [TCDM_ADDR_W-1:0] BURST0_ADDR = 20'h00400;  // model word 256
  localparam logic [TCDM_ADDR_W-1:0] BURST1_ADDR = 20'h00800;  // model word 512

  logic              CLK;
  logic              rst_n;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;
  tcdm_req_t         tcdm_req [N_CHAN];
  tcdm_rsp_t         tcdm_rsp [N_CHAN];
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic [1:0]        stall;
  logic [1:0]        slow;
  logic [1:0]        ld_en;
  logic [9:0]        ld_idx;
  logic [DATA_W-1:0] ld_data;
  logic              stall_on;
  logic [31:0]       lfsr;
  logic [DATA_W-1:0] ram_exp [16];
  logic [DATA_W-1:0] pre1 [16];
  logic [DATA_W-1:0] win0 [8];
  logic [DATA_W-1:0] win1 [8];

  efpga_test_top uut (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .tcdm_req (tcdm_req),
    .tcdm_rsp (tcdm_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  tb_tcdm_mem u_mem0 (
    .CLK (CLK), .rst_n (rst_n), .stall (stall[0]), .slow (slow[0]),
    .ld_en (ld_en[0]), .ld_idx (ld_idx), .ld_data (ld_data),
    .req (tcdm_req[0]), .rsp (tcdm_rsp[0])
  );

  tb_tcdm_mem u_mem1 (
    .CLK (CLK), .rst_n (rst_n), .stall (stall[1]), .slow (slow[1]),
    .ld_en (ld_en[1]), .ld_idx (ld_idx), .ld_data (ld_data),
    .req (tcdm_req[1]), .rsp (tcdm_rsp[1])
  );

  // galois lfsr stepped once per bit
  function automatic logic [GPIO_W-1:0] rand_bits(input int n);
    logic [GPIO_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[GPIO_W-2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] cfg_word(input logic dir, input logic [3:0] lane_dis,
                                                 input logic [TCDM_ADDR_W-1:0] addr);
    return {dir, 7'b0, lane_dis, addr};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [GPIO_W-1:0] exp,
                             input logic [GPIO_W-1:0] act);
    assert (act === exp) else begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run("value mismatch");
    end
  endtask

  // one clock step with stalls refreshed on the falling edge
  task automatic tick();
    @(negedge CLK);
    if (stall_on) begin
      stall = 2'(rand_bits(2));
      slow  = 2'(rand_bits(2));
    end else begin
      stall = '0;
      slow  = '0;
    end
  endtask

  task automatic bus_access(input logic we, input logic [BUS_ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
    int cycles;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    cycles     = 0;
    do begin
      tick();
      cycles++;
    end while (!wb_rsp.ack && cycles < 8);
    if (!wb_rsp.ack) begin
      abort_run($sformatf("no ack for bus access at %h", adr));
    end
    check_value("wb_rsp.ack delay", GPIO_W'(2), GPIO_W'(cycles));
    rdat       = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    tick();
    check_value("wb_rsp.ack", '0, GPIO_W'(wb_rsp.ack));  // single-cycle ack
  endtask

  task automatic bus_write(input logic [BUS_ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
    logic [DATA_W-1:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input logic [BUS_ADDR_W-1:0] adr, output logic [DATA_W-1:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic wait_idle(input int ch);
    logic [DATA_W-1:0] b;
    int                polls;
    polls = 0;
    do begin
      bus_read(ADDR_BUSY, b);
      polls++;
    end while (b[ch] && polls < 200);
    if (b[ch]) begin
      abort_run($sformatf("channel %0d still busy after %0d polls", ch, polls));
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    logic [DATA_W-1:0]            rd;
    logic [DATA_W-1:0]            d;
    logic [DATA_W-1:0]            merged;
    logic [GPIO_WORDS*DATA_W-1:0] out_ext;
    logic [GPIO_WORDS*DATA_W-1:0] oe_ext;
    logic [GPIO_WORDS*DATA_W-1:0] in_ext;
    lfsr     = 32'd37;
    rst_n    = 1'b0;
    wb_req   = '0;
    gpio_in  = '0;
    stall    = '0;
    slow     = '0;
    ld_en    = '0;
    ld_idx   = '0;
    ld_data  = '0;
    stall_on = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;

    check_value("wb_rsp.ack", '0, GPIO_W'(wb_rsp.ack));
    check_value("tcdm_req[0].req", '0, GPIO_W'(tcdm_req[0].req));
    check_value("tcdm_req[1].req", '0, GPIO_W'(tcdm_req[1].req));
    check_value("gpio_out", '0, gpio_out);
    check_value("gpio_oe", '0, gpio_oe);
    for (int ch = 0; ch < N_CHAN; ch++) begin
      bus_read(ADDR_CFG_BASE + BUS_ADDR_W'(4 * ch), rd);
      check_value($sformatf("wb_rsp.dat cfg%0d", ch), '0, GPIO_W'(rd));
    end
    bus_read(ADDR_BUSY, rd);
    check_value("wb_rsp.dat busy", '0, GPIO_W'(rd));
    bus_read(ADDR_ID, rd);
    check_value("wb_rsp.dat id", GPIO_W'(32'hCA11_EF3A), GPIO_W'(rd));
    bus_read(20'h00300, rd);  // nothing mapped here
    check_value("wb_rsp.dat unmapped", '0, GPIO_W'(rd));

    out_ext = '0;
    oe_ext  = '0;
    for (int w = 0; w < GPIO_WORDS; w++) begin
      d = DATA_W'(rand_bits(DATA_W));
      bus_write(ADDR_GPIO_OUT + BUS_ADDR_W'(4 * w), d);
      out_ext[w*DATA_W +: DATA_W] = d;
      d = DATA_W'(rand_bits(DATA_W));
      bus_write(ADDR_GPIO_OE + BUS_ADDR_W'(4 * w), d);
      oe_ext[w*DATA_W +: DATA_W] = d;
    end
    out_ext[GPIO_WORDS*DATA_W-1:GPIO_W] = '0;  // top word is 16 bits wide
    oe_ext[GPIO_WORDS*DATA_W-1:GPIO_W]  = '0;
    check_value("gpio_out", out_ext[GPIO_W-1:0], gpio_out);
    check_value("gpio_oe", oe_ext[GPIO_W-1:0], gpio_oe);
    in_ext                = '0;
    in_ext[GPIO_W-1:0]    = rand_bits(GPIO_W);
    gpio_in               = in_ext[GPIO_W-1:0];
    for (int w = 0; w < GPIO_WORDS; w++) begin
      bus_read(ADDR_GPIO_OUT + BUS_ADDR_W'(4 * w), rd);
      check_value("wb_rsp.dat gpio_out", GPIO_W'(out_ext[w*DATA_W +: DATA_W]), GPIO_W'(rd));
      bus_read(ADDR_GPIO_OE + BUS_ADDR_W'(4 * w), rd);
      check_value("wb_rsp.dat gpio_oe", GPIO_W'(oe_ext[w*DATA_W +: DATA_W]), GPIO_W'(rd));
      bus_read(ADDR_GPIO_IN + BUS_ADDR_W'(4 * w), rd);
      check_value("wb_rsp.dat gpio_in", GPIO_W'(in_ext[w*DATA_W +: DATA_W]), GPIO_W'(rd));
    end

    // same word indices in both windows up to word 255
    for (int i = 0; i < 8; i++) begin
      win0[i] = DATA_W'(rand_bits(DATA_W));
      win1[i] = DATA_W'(rand_bits(DATA_W));
      bus_write(RAM_WIN_BASE + BUS_ADDR_W'(144 * i + 12), win0[i]);
      bus_write(RAM_WIN_BASE + RAM_WIN_STRIDE + BUS_ADDR_W'(144 * i + 12), win1[i]);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(RAM_WIN_BASE + BUS_ADDR_W'(144 * i + 12), rd);
      check_value("wb_rsp.dat ram0", GPIO_W'(win0[i]), GPIO_W'(rd));
      bus_read(RAM_WIN_BASE + RAM_WIN_STRIDE + BUS_ADDR_W'(144 * i + 12), rd);
      check_value("wb_rsp.dat ram1", GPIO_W'(win1[i]), GPIO_W'(rd));
    end

    for (int i = 0; i < 16; i++) begin
      ram_exp[i] = DATA_W'(rand_bits(DATA_W));
      bus_write(RAM_WIN_BASE + BUS_ADDR_W'(4 * i), ram_exp[i]);
    end
    bus_write(ADDR_CFG_BASE, cfg_word(1'b0, 4'b0000, BURST0_ADDR));
    stall_on = 1'b1;
    bus_write(ADDR_LAUNCH_BASE, 32'd16);
    wait_idle(0);
    stall_on = 1'b0;
    for (int i = 0; i < 16; i++) begin
      check_value($sformatf("u_mem0.mem[%0d]", 256 + i), GPIO_W'(ram_exp[i]),
                  GPIO_W'(u_mem0.mem[256 + i]));
    end
    bus_read(ADDR_CFG_BASE, rd);
    check_value("wb_rsp.dat cfg0", GPIO_W'(cfg_word(1'b0, 4'b0000, BURST0_ADDR + 20'd64)),
                GPIO_W'(rd));

    for (int i = 0; i < 16; i++) begin
      pre1[i] = DATA_W'(rand_bits(DATA_W));
      ld_en   = 2'b10;
      ld_idx  = 10'(512 + i);
      ld_data = pre1[i];
      tick();
    end
    ld_en = '0;
    bus_write(ADDR_CFG_BASE + 20'h4, cfg_word(1'b1, 4'b0000, BURST1_ADDR));
    stall_on = 1'b1;
    bus_write(ADDR_LAUNCH_BASE + 20'h4, 32'd16);
    wait_idle(1);
    stall_on = 1'b0;
    for (int i = 0; i < 16; i++) begin
      bus_read(RAM_WIN_BASE + RAM_WIN_STRIDE + BUS_ADDR_W'(4 * i), rd);
      check_value("wb_rsp.dat ram1", GPIO_W'(pre1[i]), GPIO_W'(rd));
    end

    // lanes 0 and 2 off on a word the first burst wrote
    bus_write(ADDR_CFG_BASE, cfg_word(1'b0, 4'b0101, BURST0_ADDR + 20'd20));
    d = DATA_W'(rand_bits(DATA_W));
    bus_write(ADDR_DIRECT_BASE, d);
    wait_idle(0);
    merged = ram_exp[5];
    for (int b = 0; b < 4; b++) begin
      if (b == 1 || b == 3) begin
        merged[8*b +: 8] = d[8*b +: 8];
      end
    end
    check_value("u_mem0.mem[261]", GPIO_W'(merged), GPIO_W'(u_mem0.mem[261]));
    bus_write(ADDR_CFG_BASE, cfg_word(1'b1, 4'b0000, BURST0_ADDR + 20'd20));
    bus_write(ADDR_DIRECT_BASE, '0);
    wait_idle(0);
    bus_read(ADDR_DIRECT_BASE, rd);
    check_value("wb_rsp.dat direct", GPIO_W'(merged), GPIO_W'(rd));

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: tb_tcdm_mem.sv
`timescale 1ns/1ps

/*
  TCDM memory model for the testbench
  1024 words with byte-enable writes, grant stalls, a one or two
  cycle response and a preload port
*/
module tb_tcdm_mem (
  input  logic                              CLK,
  input  logic                              rst_n,
  input  logic                              stall,    // holds gnt low
  input  logic                              slow,     // two-cycle response
  input  logic                              ld_en,
  input  logic [9:0]                        ld_idx,
  input  logic [efpga_test_pkg::DATA_W-1:0] ld_data,
  input  efpga_test_pkg::tcdm_req_t         req,
  output efpga_test_pkg::tcdm_rsp_t         rsp
);

  import efpga_test_pkg::*;

  logic [DATA_W-1:0] mem [1024];
  logic [9:0]        idx;
  logic              pend;  // slow response in flight
  logic              rvalid;
  logic [DATA_W-1:0] rdata;

  assign idx        = req.addr[11:2];
  assign rsp.gnt    = req.req && !stall && !pend;
  assign rsp.rvalid = rvalid;
  assign rsp.rdata  = rdata;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pend   <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      pend   <= rsp.gnt && slow;
      rvalid <= pend || (rsp.gnt && !slow);
    end
  end

  always_ff @(posedge CLK) begin
    if (ld_en) begin
      mem[ld_idx] <= ld_data;
    end else if (rsp.gnt) begin
      if (req.wen) begin
        rdata <= mem[idx];  // held until rvalid
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (req.be[b]) begin
            mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// File: efpga_test_top.sv
`timescale 1ns/1ps

/*
  eFPGA test target top level
  one Wishbone slave feeding N_CHAN pairs of TCDM channel and
  dual-port operand RAM
*/
module efpga_test_top (
  input  logic                              CLK,
  input  logic                              rst_n,
  input  efpga_test_pkg::wb_req_t           wb_req,
  output efpga_test_pkg::wb_rsp_t           wb_rsp,
  output efpga_test_pkg::tcdm_req_t         tcdm_req [efpga_test_pkg::N_CHAN],
  input  efpga_test_pkg::tcdm_rsp_t         tcdm_rsp [efpga_test_pkg::N_CHAN],
  input  logic [efpga_test_pkg::GPIO_W-1:0] gpio_in,
  output logic [efpga_test_pkg::GPIO_W-1:0] gpio_out,
  output logic [efpga_test_pkg::GPIO_W-1:0] gpio_oe
);

  import efpga_test_pkg::*;

  chan_ctrl_t        chan_ctrl [N_CHAN];
  chan_stat_t        chan_stat [N_CHAN];
  ram_req_t          ram_a_req [N_CHAN];  // bus side
  ram_req_t          ram_b_req [N_CHAN];  // channel side
  logic [DATA_W-1:0] ram_a_rdata [N_CHAN];
  logic [DATA_W-1:0] ram_b_rdata [N_CHAN];

  wb_csr_target u_csr (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .chan_ctrl   (chan_ctrl),
    .chan_stat   (chan_stat),
    .ram_a_req   (ram_a_req),
    .ram_a_rdata (ram_a_rdata),
    .gpio_in     (gpio_in),
    .gpio_out    (gpio_out),
    .gpio_oe     (gpio_oe)
  );

  generate
    for (genvar k = 0; k < N_CHAN; k++) begin : g_chan
      tcdm_dma_channel u_chan (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .ctrl      (chan_ctrl[k]),
        .stat      (chan_stat[k]),
        .tcdm_req  (tcdm_req[k]),
        .tcdm_rsp  (tcdm_rsp[k]),
        .ram_req   (ram_b_req[k]),
        .ram_rdata (ram_b_rdata[k])
      );

      oper_ram u_ram (
        .CLK     (CLK),
        .a_req   (ram_a_req[k]),
        .b_req   (ram_b_req[k]),
        .a_rdata (ram_a_rdata[k]),
        .b_rdata (ram_b_rdata[k])
      );
    end
  endgenerate

endmodule

// File: wb_csr_target.sv
`timescale 1ns/1ps

/*
  Wishbone classic slave for the test target
  two-cycle access sequencer, address decode, pin registers and
  read-data mux over channels, RAM windows and the ID word
*/
module wb_csr_target (
  input  logic                              CLK,
  input  logic                              rst_n,
  input  efpga_test_pkg::wb_req_t           wb_req,
  output efpga_test_pkg::wb_rsp_t           wb_rsp,
  output efpga_test_pkg::chan_ctrl_t        chan_ctrl [efpga_test_pkg::N_CHAN],
  input  efpga_test_pkg::chan_stat_t        chan_stat [efpga_test_pkg::N_CHAN],
  output efpga_test_pkg::ram_req_t          ram_a_req [efpga_test_pkg::N_CHAN],
  input  logic [efpga_test_pkg::DATA_W-1:0] ram_a_rdata [efpga_test_pkg::N_CHAN],
  input  logic [efpga_test_pkg::GPIO_W-1:0] gpio_in,
  output logic [efpga_test_pkg::GPIO_W-1:0] gpio_out,
  output logic [efpga_test_pkg::GPIO_W-1:0] gpio_oe
);

  import efpga_test_pkg::*;

  typedef enum logic [3:0] {
    SEL_NONE, SEL_CFG, SEL_DIRECT, SEL_LAUNCH, SEL_BUSY,
    SEL_GPIO_OUT, SEL_GPIO_OE, SEL_GPIO_IN, SEL_ID, SEL_RAM
  } sel_e;

  sel_e              dec_sel;
  sel_e              rd_sel;
  logic [1:0]        dec_idx;  // channel or pin word
  logic [1:0]        rd_idx;
  logic              start;
  logic              wr_go;
  logic              pend;
  logic              ack_q;
  logic [N_CHAN-1:0] busy_vec;
  logic [DATA_W-1:0] rd_mux;
  logic [DATA_W-1:0] rd_data;

  // one 32-bit slice of a pin vector, top word zero-filled
  function automatic logic [DATA_W-1:0] pin_word(input logic [GPIO_W-1:0] pins,
                                                 input logic [1:0]        w);
    logic [GPIO_WORDS*DATA_W-1:0] ext;
    ext = '0;
    ext[GPIO_W-1:0] = pins;
    return ext[w*DATA_W +: DATA_W];
  endfunction

  function automatic logic [GPIO_W-1:0] pin_update(input logic [GPIO_W-1:0] pins,
                                                   input logic [1:0]        w,
                                                   input logic [DATA_W-1:0] d);
    logic [GPIO_WORDS*DATA_W-1:0] ext;
    ext = '0;
    ext[GPIO_W-1:0] = pins;
    ext[w*DATA_W +: DATA_W] = d;
    return ext[GPIO_W-1:0];  // upper bits of top word dropped
  endfunction

  assign start = wb_req.cyc && wb_req.stb && !pend && !ack_q;  // edge k
  assign wr_go = start && wb_req.we;

  always_comb begin
    dec_sel = SEL_NONE;
    dec_idx = wb_req.adr[3:2];
    case (wb_req.adr)
      ADDR_GPIO_OUT, ADDR_GPIO_OUT + 20'h4, ADDR_GPIO_OUT + 20'h8: dec_sel = SEL_GPIO_OUT;
      ADDR_GPIO_OE, ADDR_GPIO_OE + 20'h4, ADDR_GPIO_OE + 20'h8:    dec_sel = SEL_GPIO_OE;
      ADDR_GPIO_IN, ADDR_GPIO_IN + 20'h4, ADDR_GPIO_IN + 20'h8:    dec_sel = SEL_GPIO_IN;
      ADDR_BUSY: dec_sel = SEL_BUSY;
      ADDR_ID:   dec_sel = SEL_ID;
      default:   dec_sel = SEL_NONE;
    endcase
    for (int i = 0; i < N_CHAN; i++) begin
      if (wb_req.adr == ADDR_CFG_BASE + BUS_ADDR_W'(4 * i)) begin
        dec_sel = SEL_CFG;
        dec_idx = 2'(i);
      end
      if (wb_req.adr == ADDR_DIRECT_BASE + BUS_ADDR_W'(4 * i)) begin
        dec_sel = SEL_DIRECT;
        dec_idx = 2'(i);
      end
      if (wb_req.adr == ADDR_LAUNCH_BASE + BUS_ADDR_W'(4 * i)) begin
        dec_sel = SEL_LAUNCH;
        dec_idx = 2'(i);
      end
      if ((wb_req.adr >> (RAM_ADDR_W + 2)) ==
          ((RAM_WIN_BASE + BUS_ADDR_W'(i) * RAM_WIN_STRIDE) >> (RAM_ADDR_W + 2))) begin
        dec_sel = SEL_RAM;  // first RAM_DEPTH words of the window
        dec_idx = 2'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_CHAN; i++) begin
      chan_ctrl[i].cfg_we = wr_go && dec_sel == SEL_CFG && dec_idx == 2'(i);
      chan_ctrl[i].launch = wr_go && dec_sel == SEL_LAUNCH && dec_idx == 2'(i);
      chan_ctrl[i].direct = wr_go && dec_sel == SEL_DIRECT && dec_idx == 2'(i);
      chan_ctrl[i].wdata  = wb_req.dat;
      ram_a_req[i].en     = start && dec_sel == SEL_RAM && dec_idx == 2'(i);
      ram_a_req[i].we     = wr_go && dec_sel == SEL_RAM && dec_idx == 2'(i);
      ram_a_req[i].addr   = wb_req.adr[RAM_ADDR_W+1:2];
      ram_a_req[i].wdata  = wb_req.dat;
      busy_vec[i]         = chan_stat[i].busy;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pend     <= 1'b0;
      ack_q    <= 1'b0;
      rd_sel   <= SEL_NONE;
      rd_idx   <= '0;
      gpio_out <= '0;
      gpio_oe  <= '0;
    end else begin
      pend  <= start;
      ack_q <= pend;  // single-cycle ack at edge k+1
      if (start) begin
        rd_sel <= wb_req.we ? SEL_NONE : dec_sel;
        rd_idx <= dec_idx;
      end
      if (wr_go && dec_sel == SEL_GPIO_OUT) begin
        gpio_out <= pin_update(gpio_out, dec_idx, wb_req.dat);
      end
      if (wr_go && dec_sel == SEL_GPIO_OE) begin
        gpio_oe <= pin_update(gpio_oe, dec_idx, wb_req.dat);
      end
    end
  end

  always_comb begin
    case (rd_sel)
      SEL_CFG:      rd_mux = chan_stat[rd_idx[CHAN_IDX_W-1:0]].cfg;
      SEL_DIRECT:   rd_mux = chan_stat[rd_idx[CHAN_IDX_W-1:0]].result;
      SEL_BUSY:     rd_mux = DATA_W'(busy_vec);
      SEL_GPIO_OUT: rd_mux = pin_word(gpio_out, rd_idx);
      SEL_GPIO_OE:  rd_mux = pin_word(gpio_oe, rd_idx);
      SEL_GPIO_IN:  rd_mux = pin_word(gpio_in, rd_idx);
      SEL_ID:       rd_mux = ID_WORD;
      SEL_RAM:      rd_mux = ram_a_rdata[rd_idx[CHAN_IDX_W-1:0]];  // read at edge k
      default:      rd_mux = '0;  // unmapped, launch
    endcase
  end

  always_ff @(posedge CLK) begin
    if (pend) begin
      rd_data <= rd_mux;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_data;

endmodule

// File: tcdm_dma_channel.sv
`timescale 1ns/1ps

/*
  TCDM master channel
  holds its config and result registers and runs either one direct
  access or a counted burst between operand RAM port B and TCDM
*/
module tcdm_dma_channel (
  input  logic                              CLK,
  input  logic                              rst_n,
  input  efpga_test_pkg::chan_ctrl_t        ctrl,
  output efpga_test_pkg::chan_stat_t        stat,
  output efpga_test_pkg::tcdm_req_t         tcdm_req,
  input  efpga_test_pkg::tcdm_rsp_t         tcdm_rsp,
  output efpga_test_pkg::ram_req_t          ram_req,
  input  logic [efpga_test_pkg::DATA_W-1:0] ram_rdata
);

  import efpga_test_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,  // ram read ahead of a tcdm write
    S_REQ,
    S_WAIT
  } state_e;

  state_e                 state;
  logic                   burst;
  logic                   cfg_dir;
  logic [3:0]             cfg_be;
  logic [TCDM_ADDR_W-1:0] cfg_addr;
  logic [RAM_ADDR_W-1:0]  word_idx;
  logic [RAM_ADDR_W-1:0]  remain;
  logic [RAM_ADDR_W-1:0]  launch_cnt;
  logic                   last_word;
  logic [DATA_W-1:0]      direct_wdata;
  logic [DATA_W-1:0]      result;
  logic                   ram_wr;
  logic [RAM_ADDR_W-1:0]  ram_wr_addr;
  logic [DATA_W-1:0]      ram_wr_data;

  assign launch_cnt = ctrl.wdata[RAM_ADDR_W-1:0];
  assign last_word  = (remain == RAM_ADDR_W'(1));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      burst    <= 1'b0;
      cfg_dir  <= 1'b0;
      cfg_be   <= '1;
      cfg_addr <= '0;
      word_idx <= '0;
      remain   <= '0;
      ram_wr   <= 1'b0;
    end else begin
      ram_wr <= 1'b0;
      case (state)
        S_IDLE: begin  // pulses only count here
          if (ctrl.cfg_we) begin
            cfg_dir  <= ctrl.wdata[CFG_DIR_BIT];
            cfg_be   <= ~ctrl.wdata[CFG_BE_LSB +: 4];
            cfg_addr <= ctrl.wdata[CFG_ADDR_LSB +: TCDM_ADDR_W];
          end
          if (ctrl.direct) begin
            burst <= 1'b0;
            state <= S_REQ;
          end
          if (ctrl.launch && launch_cnt != '0) begin
            burst    <= 1'b1;
            word_idx <= '0;
            remain   <= launch_cnt;
            state    <= cfg_dir ? S_REQ : S_FETCH;
          end
        end
        S_FETCH: state <= S_REQ;
        S_REQ: begin
          if (tcdm_rsp.gnt) begin
            if (burst) begin
              cfg_addr <= cfg_addr + TCDM_ADDR_W'(4);
            end
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (tcdm_rsp.rvalid) begin
            if (burst) begin
              ram_wr   <= cfg_dir;  // store read word next cycle
              word_idx <= word_idx + 1'b1;
              remain   <= remain - 1'b1;
              if (last_word) begin
                state <= S_IDLE;
              end else begin
                state <= cfg_dir ? S_REQ : S_FETCH;
              end
            end else begin
              state <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == S_IDLE && ctrl.direct) begin
      direct_wdata <= ctrl.wdata;
    end
    if (state == S_WAIT && tcdm_rsp.rvalid) begin
      if (!burst && cfg_dir) begin
        result <= tcdm_rsp.rdata;
      end
      ram_wr_addr <= word_idx;
      ram_wr_data <= tcdm_rsp.rdata;
    end
  end

  // ram_rdata holds while port B is idle during S_REQ
  always_comb begin
    tcdm_req.req   = (state == S_REQ);
    tcdm_req.addr  = cfg_addr;
    tcdm_req.wen   = cfg_dir;
    tcdm_req.be    = cfg_be;
    tcdm_req.wdata = burst ? ram_rdata : direct_wdata;
  end

  always_comb begin
    ram_req.en    = (state == S_FETCH) || ram_wr;
    ram_req.we    = ram_wr;
    ram_req.addr  = ram_wr ? ram_wr_addr : word_idx;
    ram_req.wdata = ram_wr_data;
  end

  always_comb begin
    stat.cfg                                = '0;
    stat.cfg[CFG_DIR_BIT]                   = cfg_dir;
    stat.cfg[CFG_BE_LSB +: 4]               = ~cfg_be;  // back to disable bits
    stat.cfg[CFG_ADDR_LSB +: TCDM_ADDR_W]   = cfg_addr;
    stat.result                             = result;
    stat.busy                               = (state != S_IDLE);
  end

endmodule

// File: oper_ram.sv
`timescale 1ns/1ps

/*
  operand RAM
  dual-port word memory, synchronous read and write on both ports
*/
module oper_ram (
  input  logic                              CLK,
  input  efpga_test_pkg::ram_req_t          a_req,
  input  efpga_test_pkg::ram_req_t          b_req,
  output logic [efpga_test_pkg::DATA_W-1:0] a_rdata,
  output logic [efpga_test_pkg::DATA_W-1:0] b_rdata
);

  import efpga_test_pkg::*;

  logic [DATA_W-1:0] mem [RAM_DEPTH];

  // read-before-write on each port
  always_ff @(posedge CLK) begin
    if (a_req.en) begin
      if (a_req.we) begin
        mem[a_req.addr] <= a_req.wdata;
      end
      a_rdata <= mem[a_req.addr];
    end
    if (b_req.en) begin
      if (b_req.we) begin
        mem[b_req.addr] <= b_req.wdata;  // same-word clash is undefined
      end
      b_rdata <= mem[b_req.addr];
    end
  end

endmodule

// File: efpga_test_pkg.sv
/*
  efpga test target shared definitions
  widths, register map, config word fields and the packed structs
  for the wishbone port, the tcdm channels and the operand rams
*/
package efpga_test_pkg;

  localparam int DATA_W      = 32;  // bus, tcdm and ram word
  localparam int TCDM_ADDR_W = 20;  // tcdm byte address
  localparam int BUS_ADDR_W  = 20;  // wishbone byte address
  localparam int RAM_DEPTH   = 256;
  localparam int RAM_ADDR_W  = 8;
  localparam int N_CHAN      = 2;   // channel/ram pairs
  localparam int CHAN_IDX_W  = $clog2(N_CHAN);
  localparam int GPIO_W      = 80;
  localparam int GPIO_WORDS  = (GPIO_W + DATA_W - 1) / DATA_W;

  localparam logic [DATA_W-1:0] ID_WORD = 32'hCA11_EF3A;

  // register map, byte addresses
  localparam logic [BUS_ADDR_W-1:0] ADDR_CFG_BASE    = 20'h00000;  // stride 4
  localparam logic [BUS_ADDR_W-1:0] ADDR_DIRECT_BASE = 20'h00080;  // stride 4
  localparam logic [BUS_ADDR_W-1:0] ADDR_LAUNCH_BASE = 20'h00200;  // stride 4
  localparam logic [BUS_ADDR_W-1:0] ADDR_BUSY        = 20'h00210;
  localparam logic [BUS_ADDR_W-1:0] ADDR_GPIO_OUT    = 20'h00040;  // three words
  localparam logic [BUS_ADDR_W-1:0] ADDR_GPIO_OE     = 20'h00050;
  localparam logic [BUS_ADDR_W-1:0] ADDR_GPIO_IN     = 20'h00060;
  localparam logic [BUS_ADDR_W-1:0] ADDR_ID          = 20'h00800;
  localparam logic [BUS_ADDR_W-1:0] RAM_WIN_BASE     = 20'h01000;
  localparam logic [BUS_ADDR_W-1:0] RAM_WIN_STRIDE   = 20'h01000;

  // channel config word
  localparam int CFG_DIR_BIT  = 31;  // 1 = tcdm to ram
  localparam int CFG_BE_LSB   = 20;  // lane disable nibble
  localparam int CFG_ADDR_LSB = 0;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [BUS_ADDR_W-1:0] adr;
    logic [DATA_W-1:0]     dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                   req;
    logic [TCDM_ADDR_W-1:0] addr;
    logic                   wen;  // 1 = read
    logic [3:0]             be;
    logic [DATA_W-1:0]      wdata;
  } tcdm_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } tcdm_rsp_t;

  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [RAM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } ram_req_t;

  typedef struct packed {
    logic              cfg_we;  // single-cycle pulses
    logic              launch;
    logic              direct;
    logic [DATA_W-1:0] wdata;
  } chan_ctrl_t;

  typedef struct packed {
    logic [DATA_W-1:0] cfg;
    logic [DATA_W-1:0] result;
    logic              busy;
  } chan_stat_t;

endpackage
